/* hdl/cheat_code_assembler.sv */
/*
 * Cheat code assembler
 * Packs 16-byte cheat records into one 128-bit code with a valid strobe
 */
`timescale 1ns/1ps
`default_nettype none
`include "nes_loader_config.svh"

module cheat_code_assembler (
	input  wire                           clk,
	input  wire                           reset_nes,
	input  wire nes_loader_pkg::download_bus_t dl,
	output nes_loader_pkg::cheat_code_t   cheat_code,
	output logic                          cheat_valid
);
	logic       take;
	logic [1:0] word_sel;
	logic [4:0] lane_lsb;  // Bit offset of the byte in its word

	assign take     = dl.download && dl.index == `NES_CHEAT_INDEX && dl.wr;
	assign word_sel = dl.addr[3:2];
	assign lane_lsb = {dl.addr[1:0], 3'b000};

	// Each word filled least significant byte first
	always_ff @(posedge clk) begin
		if (take) begin
			case (word_sel)
			2'd0: cheat_code.flags[lane_lsb +: 8]   <= dl.data;
			2'd1: cheat_code.address[lane_lsb +: 8] <= dl.data;
			2'd2: cheat_code.compare[lane_lsb +: 8] <= dl.data;
			default: cheat_code.replace[lane_lsb +: 8] <= dl.data;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= take && dl.addr[3:0] == 4'hF;  // Last byte of the record
	end

	a_valid_single: assert property (@(posedge clk) disable iff (reset_nes)
		cheat_valid |=> !cheat_valid);

endmodule

`default_nettype wire

/* hdl/console_reset_ctrl.sv */
/*
 * Console reset control
 * Holds the console in reset around downloads and on a failed load
 */
`timescale 1ns/1ps
`default_nettype none
`include "nes_loader_config.svh"

module console_reset_ctrl (
	input  wire  clk,
	input  wire  reset_nes,
	input  wire  rom_download,
	input  wire  loader_busy,
	input  wire  loader_fail,
	output logic console_reset
);
	logic       init_done;   // Set once the first file starts
	logic [7:0] reload_cnt;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			init_done  <= 1'b0;
			reload_cnt <= '0;
		end else begin
			if (rom_download)
				init_done <= 1'b1;
			if (rom_download)
				reload_cnt <= `NES_DOWNLOAD_RESET_CYCLES;
			else if (!loader_busy && reload_cnt != '0)
				reload_cnt <= reload_cnt - 1'b1;  // Holds while loading finishes
		end
	end

	assign console_reset = !init_done || rom_download || reload_cnt != '0 || loader_fail;

endmodule

`default_nettype wire

/* hdl/ines_header_parser.sv */
/*
 * iNES header parser
 * Stores the 16 header bytes and decodes validity and mapper flags
 */
`timescale 1ns/1ps
`default_nettype none
`include "nes_loader_config.svh"

module ines_header_parser (
	input  wire                           clk,
	input  wire                           reset_nes,
	input  wire                           start,
	input  wire                           byte_wr,
	input  wire  [`NES_DATA_W-1:0]        byte_data,
	output logic                          header_done,
	output logic                          header_valid,
	output logic [`NES_DATA_W-1:0]        prg_pages,
	output logic [`NES_DATA_W-1:0]        chr_pages,
	output nes_loader_pkg::mapper_flags_t flags
);
	localparam int CNT_W = $clog2(`NES_HEADER_BYTES + 1);

	logic [CNT_W-1:0]       byte_cnt;
	logic [CNT_W-1:0]       wr_idx;
	logic                   take;
	logic [`NES_DATA_W-1:0] hdr [`NES_HEADER_BYTES];
	logic                   magic_ok;
	logic                   is_nes20;
	logic                   is_dirty;

	assign wr_idx = start ? '0 : byte_cnt;
	assign take   = byte_wr && (start || byte_cnt < CNT_W'(`NES_HEADER_BYTES));

	always_ff @(posedge clk) begin
		if (reset_nes)
			byte_cnt <= '0;
		else if (start)
			byte_cnt <= byte_wr ? CNT_W'(1) : '0;
		else if (take)
			byte_cnt <= byte_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (take)
			hdr[wr_idx[CNT_W-2:0]] <= byte_data;
	end

	// Strobe with the last header byte
	assign header_done = byte_wr && !start && byte_cnt == CNT_W'(`NES_HEADER_BYTES - 1);

	////////////////////////////////////////
	// Decode

	// Magic and trainer bit are stored before the last byte arrives
	assign magic_ok = hdr[0] == `NES_MAGIC_0 && hdr[1] == `NES_MAGIC_1 &&
	                  hdr[2] == `NES_MAGIC_2 && hdr[3] == `NES_MAGIC_3;
	assign header_valid = magic_ok && !hdr[6][2];  // Trainers not supported

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];
	assign is_nes20  = hdr[7][3:2] == 2'b10;

	// Junk in the tail of an old iNES 1.0 header
	always_comb begin
		is_dirty = |hdr[9][7:1];
		for (int i = 10; i < `NES_HEADER_BYTES; i++) begin
			is_dirty = is_dirty | (|hdr[i]);
		end
		is_dirty = is_dirty & ~is_nes20;
	end

	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if ({1'b0, pages} <= (9'd1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	always_comb begin
		flags             = '0;
		flags.mapper      = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
		flags.prg_size    = size_code(prg_pages);
		flags.chr_size    = size_code(chr_pages);
		flags.mirroring   = hdr[6][0];
		flags.has_chr_ram = chr_pages == '0;
		flags.four_screen = hdr[6][3];
		flags.submapper   = is_nes20 ? hdr[8] : 8'h00;
		flags.has_saves   = hdr[6][1];
	end

	// Header stays complete until the next download
	a_header_frozen: assert property (@(posedge clk) disable iff (reset_nes)
		(byte_cnt == CNT_W'(`NES_HEADER_BYTES) && !start) |=>
		byte_cnt == CNT_W'(`NES_HEADER_BYTES));

endmodule

`default_nettype wire

/* hdl/nes_cart_loader.sv */
/*
 * NES cartridge download front end
 * Routes the download bus to the ROM loader, cheat assembler and reset control
 */
`timescale 1ns/1ps
`default_nettype none
`include "nes_loader_config.svh"

module nes_cart_loader (
	input  wire                           clk,
	input  wire                           reset_nes,
	input  wire nes_loader_pkg::download_bus_t dl,
	input  wire                           invert_mirroring,
	output nes_loader_pkg::mem_write_t    mem,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          loader_done,
	output logic                          loader_fail,
	output logic                          console_reset,
	output nes_loader_pkg::cheat_code_t   cheat_code,
	output logic                          cheat_valid
);
	logic rom_download;  // Any file except cheats
	logic loader_busy;

	assign rom_download = dl.download && dl.index != `NES_CHEAT_INDEX;

	rom_loader_fsm u_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.dl               (dl),
		.rom_download     (rom_download),
		.invert_mirroring (invert_mirroring),
		.mem              (mem),
		.mapper_flags     (mapper_flags),
		.loader_busy      (loader_busy),
		.loader_done      (loader_done),
		.loader_fail      (loader_fail)
	);

	cheat_code_assembler u_cheat (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.dl          (dl),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	console_reset_ctrl u_reset (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.rom_download  (rom_download),
		.loader_busy   (loader_busy),
		.loader_fail   (loader_fail),
		.console_reset (console_reset)
	);

endmodule

`default_nettype wire

/* hdl/nes_loader_config.svh */
/*
 * NES cartridge loader constants
 * Widths, iNES header magic, memory bases and reset timing
 */
`ifndef NES_LOADER_CONFIG_SVH
`define NES_LOADER_CONFIG_SVH

`define NES_ADDR_W          22     // Cartridge memory address bits
`define NES_DATA_W          8
`define NES_PRG_PAGE_SHIFT  14     // 16 KiB PRG pages
`define NES_CHR_PAGE_SHIFT  13     // 8 KiB CHR pages
`define NES_CHR_BASE        (22'd1 << (`NES_ADDR_W - 1))

// iNES header
`define NES_HEADER_BYTES    16
`define NES_MAGIC_0         8'h4E  // N
`define NES_MAGIC_1         8'h45  // E
`define NES_MAGIC_2         8'h53  // S
`define NES_MAGIC_3         8'h1A

`define NES_CHEAT_INDEX     8'hFF  // Download index of a cheat file
`define NES_DOWNLOAD_RESET_CYCLES 8'd255

`endif

/* hdl/nes_loader_pkg.sv */
/*
 * NES loader shared types
 * Download bus, memory write, mapper flags, cheat code and loader states
 */
`default_nettype none
`include "nes_loader_config.svh"

package nes_loader_pkg;

	typedef struct packed {
		logic                   download;  // High for the whole file
		logic [7:0]             index;     // File type
		logic [24:0]            addr;
		logic                   wr;        // One strobe per byte
		logic [`NES_DATA_W-1:0] data;
	} download_bus_t;

	typedef struct packed {
		logic                   wr;
		logic [`NES_ADDR_W-1:0] addr;
		logic [`NES_DATA_W-1:0] data;
	} mem_write_t;

	// Same bit layout as the console core expects
	typedef struct packed {
		logic [5:0] pad;
		logic       has_saves;
		logic [7:0] submapper;
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef enum logic [2:0] {HEADER, PRG, CHR, ERROR, DONE} loader_state_e;

endpackage

`default_nettype wire

/* hdl/rom_loader_fsm.sv */
/*
 * ROM loader
 * Walks header, PRG and CHR, writes cartridge memory and latches mapper flags
 */
`timescale 1ns/1ps
`default_nettype none
`include "nes_loader_config.svh"

module rom_loader_fsm (
	input  wire                           clk,
	input  wire                           reset_nes,
	input  wire nes_loader_pkg::download_bus_t dl,
	input  wire                           rom_download,
	input  wire                           invert_mirroring,
	output nes_loader_pkg::mem_write_t    mem,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          loader_busy,
	output logic                          loader_done,
	output logic                          loader_fail
);
	nes_loader_pkg::loader_state_e state;
	nes_loader_pkg::mapper_flags_t hdr_flags;
	nes_loader_pkg::mapper_flags_t done_flags;

	logic                   rom_download_q;
	logic                   start;
	logic                   byte_wr;
	logic                   header_done;
	logic                   header_valid;
	logic [`NES_DATA_W-1:0] prg_pages;
	logic [`NES_DATA_W-1:0] chr_pages;
	logic [`NES_ADDR_W-1:0] prg_len;
	logic [`NES_ADDR_W-1:0] chr_len;
	logic [`NES_ADDR_W-1:0] bytes_left;
	logic [`NES_ADDR_W-1:0] addr_cnt;
	logic                   write_now;
	logic                   finish;
	logic                   mem_wr_q;
	logic [`NES_ADDR_W-1:0] mem_addr_q;
	logic [`NES_DATA_W-1:0] mem_data_q;

	assign start   = rom_download && !rom_download_q;  // New file restarts everything
	assign byte_wr = rom_download && dl.wr;

	ines_header_parser u_header (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.start        (start),
		.byte_wr      (byte_wr),
		.byte_data    (dl.data),
		.header_done  (header_done),
		.header_valid (header_valid),
		.prg_pages    (prg_pages),
		.chr_pages    (chr_pages),
		.flags        (hdr_flags)
	);

	assign prg_len = `NES_ADDR_W'(prg_pages) << `NES_PRG_PAGE_SHIFT;
	assign chr_len = `NES_ADDR_W'(chr_pages) << `NES_CHR_PAGE_SHIFT;

	assign write_now = byte_wr && !start && (state == nes_loader_pkg::PRG ||
	                   (state == nes_loader_pkg::CHR && bytes_left != '0));
	assign finish    = !start && state == nes_loader_pkg::CHR && bytes_left == '0;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state          <= nes_loader_pkg::HEADER;
			rom_download_q <= 1'b0;
			bytes_left     <= '0;
			addr_cnt       <= '0;
			loader_busy    <= 1'b0;
			loader_done    <= 1'b0;
			loader_fail    <= 1'b0;
		end else begin
			rom_download_q <= rom_download;
			if (start) begin
				state       <= nes_loader_pkg::HEADER;
				loader_busy <= 1'b0;
				loader_done <= 1'b0;
				loader_fail <= 1'b0;
			end else begin
				case (state)
				nes_loader_pkg::HEADER:
					if (header_done) begin
						if (!header_valid) begin
							state       <= nes_loader_pkg::ERROR;
							loader_fail <= 1'b1;
							loader_done <= 1'b1;
						end else if (prg_pages != '0) begin
							state       <= nes_loader_pkg::PRG;
							loader_busy <= 1'b1;
							bytes_left  <= prg_len;
							addr_cnt    <= '0;
						end else begin
							state       <= nes_loader_pkg::CHR;  // No PRG at all
							loader_busy <= 1'b1;
							bytes_left  <= chr_len;
							addr_cnt    <= `NES_CHR_BASE;
						end
					end
				nes_loader_pkg::PRG:
					if (byte_wr) begin
						addr_cnt   <= addr_cnt + 1'b1;
						bytes_left <= bytes_left - 1'b1;
						if (bytes_left == `NES_ADDR_W'(1)) begin
							state      <= nes_loader_pkg::CHR;
							bytes_left <= chr_len;
							addr_cnt   <= `NES_CHR_BASE;
						end
					end
				nes_loader_pkg::CHR:
					if (bytes_left == '0) begin
						state       <= nes_loader_pkg::DONE;
						loader_busy <= 1'b0;
						loader_done <= 1'b1;
					end else if (byte_wr) begin
						addr_cnt   <= addr_cnt + 1'b1;
						bytes_left <= bytes_left - 1'b1;
					end
				default: ;  // ERROR and DONE wait for the next file
				endcase
			end
		end
	end

	// Write port, one cycle behind the byte
	always_ff @(posedge clk) begin
		if (reset_nes)
			mem_wr_q <= 1'b0;
		else
			mem_wr_q <= write_now;
	end

	always_ff @(posedge clk) begin
		if (write_now) begin
			mem_addr_q <= addr_cnt;
			mem_data_q <= dl.data;
		end
	end

	always_comb begin
		mem.wr   = mem_wr_q;
		mem.addr = mem_addr_q;
		mem.data = mem_data_q;
	end

	always_comb begin
		done_flags           = hdr_flags;
		done_flags.mirroring = hdr_flags.mirroring ^ invert_mirroring;
	end

	always_ff @(posedge clk) begin
		if (finish)
			mapper_flags <= done_flags;
	end

	a_no_write_in_header: assert property (@(posedge clk) disable iff (reset_nes)
		(state == nes_loader_pkg::HEADER || state == nes_loader_pkg::ERROR) |=> !mem.wr);
	a_done_not_busy: assert property (@(posedge clk) disable iff (reset_nes)
		!(loader_done && loader_busy));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_nes_cart_loader \
	-f sources.f

# The simulator stops with a nonzero status on failure, keep its output visible
out=$(./obj_dir/Vtb_nes_cart_loader 2>&1 || true)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"

/* sources.f */
+incdir+hdl
+incdir+testbench
hdl/nes_loader_pkg.sv
hdl/ines_header_parser.sv
hdl/rom_loader_fsm.sv
hdl/cheat_code_assembler.sv
hdl/console_reset_ctrl.sv
hdl/nes_cart_loader.sv
testbench/tb_nes_cart_loader.sv

/* testbench/tb_image_tasks.svh */
/*
 * Stimulus tasks for the cartridge loader testbench
 * Build iNES headers and send images and cheat records with random gaps
 */

	// 1 PRG page and 1 CHR page, other fields from the caller
	task automatic fill_header(input logic [7:0] flags6, input logic [7:0] flags7,
	                           input logic [7:0] byte8, input logic [7:0] junk,
	                           input logic magic_ok);
		header[0] = `NES_MAGIC_0;
		header[1] = `NES_MAGIC_1;
		header[2] = `NES_MAGIC_2;
		header[3] = magic_ok ? `NES_MAGIC_3 : 8'h1B;
		header[4] = 8'd1;
		header[5] = 8'd1;
		header[6] = flags6;
		header[7] = flags7;
		header[8] = byte8;
		for (int i = 9; i < 16; i++)
			header[i] = 8'h00;
		header[12] = junk;  // Nonzero makes an old header dirty
	endtask

	task automatic open_download(input logic [7:0] index);
		@(negedge clk);
		dl.download  = 1'b1;
		dl.index     = index;
		dl.wr        = 1'b0;
		store_byte   = 1'b0;
		write_count  = 0;
	endtask

	task automatic close_download();
		@(negedge clk);
		dl.download = 1'b0;  // Straight after the last byte
		dl.index    = 8'h00;
		dl.wr       = 1'b0;
		store_byte  = 1'b0;
	endtask

	task automatic send_byte(input int offset, input logic [7:0] data, input logic stores,
	                         input logic [`NES_ADDR_W-1:0] addr);
		int gap;
		gap = $unsigned($random(seed)) % 3;
		repeat (gap) begin
			@(negedge clk);
			dl.wr      = 1'b0;
			store_byte = 1'b0;
		end
		@(negedge clk);
		dl.wr      = 1'b1;
		dl.addr    = 25'(offset);
		dl.data    = data;
		store_byte = stores;
		store_addr = addr;
	endtask

	// Header, then PRG and CHR, or 64 stray bytes when the header is bad
	task automatic send_rom_image();
		int                     prg_len;
		int                     rom_len;
		logic                   valid;
		logic [7:0]             b;
		logic [`NES_ADDR_W-1:0] waddr;
		valid   = header[0] == `NES_MAGIC_0 && header[1] == `NES_MAGIC_1 &&
		          header[2] == `NES_MAGIC_2 && header[3] == `NES_MAGIC_3 && !header[6][2];
		prg_len = int'(header[4]) << `NES_PRG_PAGE_SHIFT;
		rom_len = valid ? prg_len + (int'(header[5]) << `NES_CHR_PAGE_SHIFT) : 64;
		open_download(8'h01);
		for (int k = 0; k < 16 + rom_len; k++) begin
			if (k < 16) begin
				b     = header[k];
				waddr = '0;
			end else begin
				b     = 8'($random(seed));
				waddr = (k - 16 < prg_len) ? `NES_ADDR_W'(k - 16)
				                           : `NES_CHR_BASE + `NES_ADDR_W'(k - 16 - prg_len);
			end
			send_byte(k, b, valid && k >= 16, waddr);
		end
		close_download();
	endtask

	task automatic send_cheat_record();
		logic [7:0] b;
		open_download(`NES_CHEAT_INDEX);
		cheat_pulses = 0;
		for (int i = 0; i < 16; i++) begin
			b = 8'($random(seed));
			cheat_words[i / 4][8 * (i % 4) +: 8] = b;  // Low byte first
			send_byte(i, b, 1'b0, '0);
		end
		close_download();
	endtask

/* testbench/tb_nes_cart_loader.sv */
/*
 * Testbench for the NES cartridge download front end
 * Sends iNES images and a cheat record, checks writes, flags and console reset
 */
`timescale 1ns/1ps
`default_nettype none
`include "nes_loader_config.svh"

module tb_nes_cart_loader;
	localparam int TIMEOUT_CYCLES = 200_000;  // Two full images with gaps plus margin

	logic                          clk = 1'b0;
	logic                          reset_nes;
	logic                          invert_mirroring;
	nes_loader_pkg::download_bus_t dl;
	nes_loader_pkg::mem_write_t    mem;
	nes_loader_pkg::mapper_flags_t mapper_flags;
	nes_loader_pkg::cheat_code_t   cheat_code;
	logic                          loader_done;
	logic                          loader_fail;
	logic                          console_reset;
	logic                          cheat_valid;

	// Reference model state
	logic                          store_byte;  // Current byte must reach memory
	logic [`NES_ADDR_W-1:0]        store_addr;
	nes_loader_pkg::mem_write_t    expected_mem;
	logic [7:0]                    header [16];
	logic [3:0][31:0]              cheat_words;
	integer                        seed;
	int                            write_count;
	int                            cheat_pulses;
	int                            cycle_count = 0;

	always #2 clk = ~clk;

	nes_cart_loader u_dut (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.dl               (dl),
		.invert_mirroring (invert_mirroring),
		.mem              (mem),
		.mapper_flags     (mapper_flags),
		.loader_done      (loader_done),
		.loader_fail      (loader_fail),
		.console_reset    (console_reset),
		.cheat_code       (cheat_code),
		.cheat_valid      (cheat_valid)
	);

	task automatic stop_on_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tb_image_tasks.svh"

	////////////////////////////////////////
	// Expected mapper flags

	function automatic logic [2:0] size_code(input int pages);
		int k;
		k = 0;
		while (k < 7 && pages > (1 << k))
			k++;
		return 3'(k);
	endfunction

	function automatic nes_loader_pkg::mapper_flags_t expected_flags();
		nes_loader_pkg::mapper_flags_t f;
		logic nes20;
		logic dirty;
		nes20 = header[7][3:2] == 2'd2;
		dirty = header[9] > 8'd1;  // Bit 0 of byte 9 ignored
		for (int i = 10; i < 16; i++)
			dirty = dirty || header[i] != 8'h00;
		f             = '0;
		f.mapper      = {(dirty && !nes20) ? 4'h0 : header[7][7:4], header[6][7:4]};
		f.prg_size    = size_code(header[4]);
		f.chr_size    = size_code(header[5]);
		f.mirroring   = header[6][0] ^ invert_mirroring;
		f.has_chr_ram = header[5] == 8'd0;
		f.four_screen = header[6][3];
		f.submapper   = nes20 ? header[8] : 8'h00;
		f.has_saves   = header[6][1];
		return f;
	endfunction

	// Done, flags and write count, then the console reset countdown
	task automatic check_valid_load();
		nes_loader_pkg::mapper_flags_t want;
		int                            cycles;
		int                            rom_bytes;
		want      = expected_flags();
		rom_bytes = (int'(header[4]) << `NES_PRG_PAGE_SHIFT) +
		            (int'(header[5]) << `NES_CHR_PAGE_SHIFT);
		cycles    = 0;
		while (console_reset && cycles < 300) begin
			@(negedge clk);
			cycles++;
			if (cycles == 2) begin
				assert (loader_done && !loader_fail)
					else stop_on_error("loader_done not raised after a valid image");
				assert (mapper_flags == want)
					else stop_on_error($sformatf("mapper_flags %h, expected %h", mapper_flags, want));
			end
		end
		assert (cycles == 256)
			else stop_on_error($sformatf("console_reset fell after %0d cycles, expected 256", cycles));
		assert (write_count == rom_bytes)
			else stop_on_error($sformatf("%0d writes, expected %0d", write_count, rom_bytes));
	endtask

	////////////////////////////////////////
	// Write checker, one cycle behind each byte

	always @(posedge clk) begin
		if (reset_nes)
			expected_mem.wr <= 1'b0;
		else
			expected_mem.wr <= dl.wr && store_byte;
		expected_mem.addr <= store_addr;
		expected_mem.data <= dl.data;
	end

	always @(negedge clk) begin
		if (!reset_nes) begin
			assert (mem.wr == expected_mem.wr)
				else stop_on_error($sformatf("mem.wr %b, expected %b", mem.wr, expected_mem.wr));
			if (expected_mem.wr) begin
				assert (mem == expected_mem)
					else stop_on_error($sformatf("write %h <= %h, expected %h <= %h",
						mem.addr, mem.data, expected_mem.addr, expected_mem.data));
				write_count++;
			end
			if (cheat_valid)
				cheat_pulses++;
		end
	end

	a_reset_in_rom_download: assert property (@(posedge clk) disable iff (reset_nes)
		(dl.download && dl.index != `NES_CHEAT_INDEX) |-> console_reset)
		else stop_on_error("console_reset low during a ROM download");
	a_cheat_leaves_console: assert property (@(posedge clk) disable iff (reset_nes)
		(dl.download && dl.index == `NES_CHEAT_INDEX) |-> !console_reset)
		else stop_on_error("cheat download raised console_reset");
	a_cheat_single_pulse: assert property (@(posedge clk) disable iff (reset_nes)
		cheat_valid |=> !cheat_valid)
		else stop_on_error("cheat_valid longer than one cycle");

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		seed             = 32'hd855_f2a0;
		reset_nes        = 1'b1;
		invert_mirroring = 1'b0;
		dl               = '0;
		store_byte       = 1'b0;
		store_addr       = '0;
		write_count      = 0;
		cheat_pulses     = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_nes = 1'b0;

		assert (console_reset && !mem.wr && !loader_done && !loader_fail && !cheat_valid)
			else stop_on_error("outputs not idle after reset");
		repeat (20) begin
			@(negedge clk);
			assert (console_reset) else stop_on_error("console_reset fell before any download");
		end

		// Old header with junk in byte 12, mapper high nibble dropped
		invert_mirroring = 1'b1;
		fill_header(8'h43, 8'h10, 8'h05, 8'h44, 1'b1);
		send_rom_image();
		check_valid_load();

		fill_header(8'h00, 8'h00, 8'h00, 8'h00, 1'b0);  // Bad magic
		send_rom_image();
		assert (loader_fail && loader_done) else stop_on_error("bad magic not reported");
		repeat (300) begin
			@(negedge clk);
			assert (console_reset) else stop_on_error("console_reset fell after a failed load");
		end
		assert (write_count == 0) else stop_on_error("memory written for a bad image");

		// NES 2.0 header, submapper kept and junk ignored
		invert_mirroring = 1'b0;
		fill_header(8'h19, 8'h28, 8'h31, 8'h07, 1'b1);
		send_rom_image();
		check_valid_load();

		send_cheat_record();
		repeat (4) @(negedge clk);
		assert (cheat_pulses == 1 && write_count == 0)
			else stop_on_error($sformatf("%0d cheat pulses, %0d writes", cheat_pulses, write_count));
		assert (cheat_code.flags == cheat_words[0] && cheat_code.address == cheat_words[1] &&
		        cheat_code.compare == cheat_words[2] && cheat_code.replace == cheat_words[3])
			else stop_on_error($sformatf("cheat_code %h, expected %h", cheat_code, cheat_words));

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
